/* hdl/execPkg.sv */
`default_nettype none

package execPkg;

    // Datapath sizes
    localparam int DataWidth    = 32;
    localparam int RegCount     = 16;
    localparam int RegAddrWidth = 4;
    localparam int FlagWidth    = 7;

    // Flag word layout
    localparam int FlagOverflow  = 6;
    localparam int FlagAbove     = 5;
    localparam int FlagEqual     = 4;
    localparam int FlagBelow     = 3;
    localparam int FlagBetween   = 2; // Reserved, never set
    localparam int FlagCollision = 1; // Reserved, never set
    localparam int FlagError     = 0;

    // Code 0 is left unnamed and decodes as invalid
    typedef enum logic [3:0] {
        OpAdd = 4'd1,
        OpSub = 4'd2,
        OpMul = 4'd3,
        OpDiv = 4'd4,
        OpMov = 4'd5,
        OpSlw = 4'd6,  // Second operand move
        OpAnd = 4'd7,
        OpOr  = 4'd8,
        OpShl = 4'd9,
        OpShr = 4'd10, // Arithmetic
        OpCmp = 4'd11,
        OpNot = 4'd12,
        OpJmp = 4'd13,
        OpBfj = 4'd14, // Branch on flags
        OpNop = 4'd15
    } aluOp;

    // BFJ second operand: bits 6..0 mask, bits 13..7 wanted flag values

    typedef struct packed {
        aluOp                    op;
        logic [RegAddrWidth-1:0] rd;
        logic [RegAddrWidth-1:0] rs1;
        logic [RegAddrWidth-1:0] rs2;
        logic                    useImm; // Immediate replaces second operand
        logic [DataWidth-1:0]    imm;
    } instrT;

    typedef struct packed {
        logic [DataWidth-1:0]    result;
        logic                    zero;
        logic [FlagWidth-1:0]    flags;
        logic [RegAddrWidth-1:0] rd;
    } resultT;

    // Contents of the execute stage register
    typedef struct packed {
        aluOp                    op;
        logic [RegAddrWidth-1:0] rd;
        logic [DataWidth-1:0]    data1;
        logic [DataWidth-1:0]    data2;
        logic                    writeReg;
        logic                    writeFlags;
    } issueT;

endpackage

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire execPkg::aluOp                         operation,
    input  wire logic signed [execPkg::DataWidth-1:0]  data1,
    input  wire logic signed [execPkg::DataWidth-1:0]  data2,
    input  wire logic [execPkg::FlagWidth-1:0]         storedFlags,
    output logic                                       zero,
    output logic signed [execPkg::DataWidth-1:0]       result,
    output logic [execPkg::FlagWidth-1:0]              flags
);

    logic signed [2*execPkg::DataWidth-1:0] mulResult;
    logic                                   match;

    always_comb begin
        result    = '0;
        zero      = 1'b0;
        flags     = '0;
        match     = 1'b1;
        mulResult = '0;

        case (operation)
            execPkg::OpAdd: begin
                result = data1 + data2;
                // Same input signs, different result sign
                if ((data1[31] == data2[31]) && (result[31] != data1[31]))
                    flags[execPkg::FlagOverflow] = 1'b1;
            end

            execPkg::OpSub: begin
                result = data1 - data2;
                if ((data1[31] != data2[31]) && (result[31] != data1[31]))
                    flags[execPkg::FlagOverflow] = 1'b1;
            end

            execPkg::OpMul: begin
                mulResult = 64'(data1) * 64'(data2);
                result    = mulResult[31:0];
                // Upper half must be pure sign extension
                if (mulResult[63:31] != {33{mulResult[31]}}) begin
                    flags[execPkg::FlagOverflow] = 1'b1;
                    flags[execPkg::FlagError]    = 1'b1;
                end
            end

            execPkg::OpDiv: begin
                if (data2 == 0) begin
                    result = '0;
                    flags[execPkg::FlagError] = 1'b1; // Divide by zero
                end else begin
                    result = data1 / data2;
                end
            end

            execPkg::OpMov: result = data1;
            execPkg::OpSlw: result = data2;
            execPkg::OpAnd: result = data1 & data2;
            execPkg::OpOr:  result = data1 | data2;

            // Shift amount in data1, value in data2
            execPkg::OpShl: result = data2 << $unsigned(data1);
            execPkg::OpShr: result = data2 >>> $unsigned(data1);

            execPkg::OpCmp: begin
                if (data1 == data2)
                    flags[execPkg::FlagEqual] = 1'b1;
                else if (data1 > data2)
                    flags[execPkg::FlagAbove] = 1'b1;
                else
                    flags[execPkg::FlagBelow] = 1'b1;
            end

            execPkg::OpNot: result = ~data2;

            execPkg::OpJmp: zero = 1'b1;

            execPkg::OpBfj: begin
                for (int i = 0; i < execPkg::FlagWidth; i++) begin
                    if (data2[i] && (storedFlags[i] != data2[i+execPkg::FlagWidth]))
                        match = 1'b0;
                end
                zero = match;
            end

            execPkg::OpNop: begin
                result = '0;
                zero   = 1'b1;
            end

            default: begin
                // Invalid opcode
                result = '0;
                zero   = 1'b1;
                flags[execPkg::FlagError] = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [execPkg::RegAddrWidth-1:0]  readAddrA,
    input  wire logic [execPkg::RegAddrWidth-1:0]  readAddrB,
    input  wire logic                              writeEn,
    input  wire logic [execPkg::RegAddrWidth-1:0]  writeAddr,
    input  wire logic [execPkg::DataWidth-1:0]     writeData,
    output logic [execPkg::DataWidth-1:0]          readDataA,
    output logic [execPkg::DataWidth-1:0]          readDataB
);

    logic [execPkg::DataWidth-1:0] regs [execPkg::RegCount];

    // One write port, committed at the end of the execute cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < execPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Reads see stored contents only
    // A write on the same edge is covered by forwarding in the control
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

/* hdl/flagRegister.sv */
`timescale 1ns/1ps
`default_nettype none

module flagRegister (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           flagWriteEn,
    input  wire logic [execPkg::FlagWidth-1:0]  flagsIn,
    output logic [execPkg::FlagWidth-1:0]       storedFlags
);

    // Between and collision are never stored
    always_ff @(posedge clk) begin
        if (rst) begin
            storedFlags <= '0;
        end else if (flagWriteEn) begin
            storedFlags <= flagsIn; // Whole word replaced
            storedFlags[execPkg::FlagBetween]   <= 1'b0;
            storedFlags[execPkg::FlagCollision] <= 1'b0;
        end
    end

    // An unknown enable would silently corrupt the branch state
    assert property (@(posedge clk) disable iff (rst) !$isunknown(flagWriteEn))
        else $error("flagRegister: flagWriteEn unknown");

endmodule

`default_nettype wire

/* hdl/executeControl.sv */
`timescale 1ns/1ps
`default_nettype none

module executeControl (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              inValid,
    input  wire execPkg::instrT                    instr,
    input  wire logic [execPkg::DataWidth-1:0]     readDataA,
    input  wire logic [execPkg::DataWidth-1:0]     readDataB,
    input  wire logic [execPkg::DataWidth-1:0]     aluResult,
    input  wire logic                              aluZero,
    input  wire logic [execPkg::FlagWidth-1:0]     aluFlags,
    output logic [execPkg::RegAddrWidth-1:0]       readAddrA,
    output logic [execPkg::RegAddrWidth-1:0]       readAddrB,
    output execPkg::issueT                         issue,
    output logic                                   writeEn,
    output logic [execPkg::RegAddrWidth-1:0]       writeAddr,
    output logic [execPkg::DataWidth-1:0]          writeData,
    output logic                                   flagWriteEn,
    output logic [execPkg::FlagWidth-1:0]          flagsIn,
    output logic                                   outValid,
    output execPkg::resultT                        out
);

    logic                          issueValid;
    logic                          decWriteReg;
    logic                          decWriteFlags;
    logic                          fwdA;
    logic                          fwdB;
    logic [execPkg::DataWidth-1:0] operandA;
    logic [execPkg::DataWidth-1:0] operandB;

    // Write classes of the incoming opcode
    always_comb begin
        decWriteReg   = 1'b0;
        decWriteFlags = 1'b0;
        case (instr.op)
            execPkg::OpAdd, execPkg::OpSub, execPkg::OpMul, execPkg::OpDiv: begin
                decWriteReg   = 1'b1;
                decWriteFlags = 1'b1;
            end
            execPkg::OpMov, execPkg::OpSlw, execPkg::OpAnd, execPkg::OpOr,
            execPkg::OpShl, execPkg::OpShr, execPkg::OpNot: decWriteReg = 1'b1;
            execPkg::OpCmp: decWriteFlags = 1'b1;
            execPkg::OpJmp, execPkg::OpBfj, execPkg::OpNop: begin
            end
            default: decWriteFlags = 1'b1; // Invalid op still records its error
        endcase
    end

    assign readAddrA = instr.rs1;
    assign readAddrB = instr.rs2;

    // Instruction in the stage writes back on this same edge
    assign fwdA = issueValid && issue.writeReg && (issue.rd == instr.rs1);
    assign fwdB = issueValid && issue.writeReg && (issue.rd == instr.rs2);

    assign operandA = fwdA ? aluResult : readDataA;
    assign operandB = instr.useImm ? instr.imm : (fwdB ? aluResult : readDataB);

    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= 1'b0;
            outValid   <= 1'b0;
        end else begin
            issueValid <= inValid;
            outValid   <= issueValid;
        end
    end

    // Stage and output payload
    always_ff @(posedge clk) begin
        if (inValid) begin
            issue.op         <= instr.op;
            issue.rd         <= instr.rd;
            issue.data1      <= operandA;
            issue.data2      <= operandB;
            issue.writeReg   <= decWriteReg;
            issue.writeFlags <= decWriteFlags;
        end
        if (issueValid)
            out <= '{result: aluResult, zero: aluZero, flags: aluFlags, rd: issue.rd};
    end

    // Commit at the end of the ALU cycle
    assign writeEn     = issueValid && issue.writeReg;
    assign writeAddr   = issue.rd;
    assign writeData   = aluResult;
    assign flagWriteEn = issueValid && issue.writeFlags;
    assign flagsIn     = aluFlags;

endmodule

`default_nettype wire

/* hdl/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            inValid,
    input  wire execPkg::instrT  instr,
    output logic                 outValid,
    output execPkg::resultT      out
);

    logic [execPkg::RegAddrWidth-1:0] readAddrA;
    logic [execPkg::RegAddrWidth-1:0] readAddrB;
    logic [execPkg::DataWidth-1:0]    readDataA;
    logic [execPkg::DataWidth-1:0]    readDataB;
    execPkg::issueT                   issue;
    logic [execPkg::DataWidth-1:0]    aluResult;
    logic                             aluZero;
    logic [execPkg::FlagWidth-1:0]    aluFlags;
    logic                             writeEn;
    logic [execPkg::RegAddrWidth-1:0] writeAddr;
    logic [execPkg::DataWidth-1:0]    writeData;
    logic                             flagWriteEn;
    logic [execPkg::FlagWidth-1:0]    flagsIn;
    logic [execPkg::FlagWidth-1:0]    storedFlags;

    executeControl u_executeControl (
        .clk         (clk),
        .rst         (rst),
        .inValid     (inValid),
        .instr       (instr),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .aluResult   (aluResult),
        .aluZero     (aluZero),
        .aluFlags    (aluFlags),
        .readAddrA   (readAddrA),
        .readAddrB   (readAddrB),
        .issue       (issue),
        .writeEn     (writeEn),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .flagWriteEn (flagWriteEn),
        .flagsIn     (flagsIn),
        .outValid    (outValid),
        .out         (out)
    );

    registerFile u_registerFile (
        .clk       (clk),
        .rst       (rst),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (writeData),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    alu u_alu (
        .operation   (issue.op),
        .data1       (issue.data1),
        .data2       (issue.data2),
        .storedFlags (storedFlags), // Already holds the previous instruction's flags
        .zero        (aluZero),
        .result      (aluResult),
        .flags       (aluFlags)
    );

    flagRegister u_flagRegister (
        .clk         (clk),
        .rst         (rst),
        .flagWriteEn (flagWriteEn),
        .flagsIn     (flagsIn),
        .storedFlags (storedFlags)
    );

endmodule

`default_nettype wire

/* verif/executeUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnitTb;

    logic            clk;
    logic            rst;
    logic            inValid;
    execPkg::instrT  instr;
    logic            outValid;
    execPkg::resultT out;

    // Test list from the cases file
    string           caseName[$];
    execPkg::instrT  caseInstr[$];
    execPkg::resultT caseExp[$];
    bit              caseBubble[$];

    // Issued tests waiting for outValid in issue order
    string           pendName[$];
    execPkg::resultT pendExp[$];
    int              pendCycle[$];

    int cycleCount = 0;
    int cycleLimit = 0;
    int doneCount  = 0;
    int failCount  = 0;
    int errorCount = 0;

    executeUnit u_executeUnit (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .instr    (instr),
        .outValid (outValid),
        .out      (out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkResult(input string name, input execPkg::resultT expected,
                               input execPkg::resultT actual, output bit ok);
        ok = 1'b1;
        if (actual.result !== expected.result) begin
            $display("Error: %s result expected %h actual %h", name, expected.result,
                     actual.result);
            ok = 1'b0;
        end
        if (actual.rd !== expected.rd) begin
            $display("Error: %s rd expected %0d actual %0d", name, expected.rd, actual.rd);
            ok = 1'b0;
        end
    endtask

    task automatic checkFlags(input string name, input execPkg::resultT expected,
                              input execPkg::resultT actual, output bit ok);
        ok = 1'b1;
        if (actual.flags !== expected.flags) begin
            $display("Error: %s flags expected %b actual %b", name, expected.flags,
                     actual.flags);
            ok = 1'b0;
        end
        if (actual.zero !== expected.zero) begin
            $display("Error: %s zero expected %b actual %b", name, expected.zero, actual.zero);
            ok = 1'b0;
        end
    endtask

    task automatic reportCase(input string name, input bit ok);
        doneCount++;
        if (ok) begin
            $display("test %s ok", name);
        end else begin
            failCount++;
            $display("test %s wrong", name);
        end
    endtask

    task automatic popPending();
        void'(pendName.pop_front());
        void'(pendExp.pop_front());
        void'(pendCycle.pop_front());
    endtask

    // Outputs settle right after the edge and are checked 1 ns later
    task automatic observeOutputs();
        bit okResult;
        bit okFlags;
        if (outValid) begin
            if (pendName.size() == 0) begin
                $display("Result for rd %0d arrived with no test pending", out.rd);
                errorCount++;
            end else begin
                checkResult(pendName[0], pendExp[0], out, okResult);
                checkFlags(pendName[0], pendExp[0], out, okFlags);
                reportCase(pendName[0], okResult && okFlags);
                popPending();
            end
        end
        // Result is due on the second edge after the sampling edge
        if (pendName.size() != 0 && cycleCount > pendCycle[0] + 2) begin
            $display("Test %s gave no result within two cycles of issue", pendName[0]);
            reportCase(pendName[0], 1'b0);
            popPending();
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
        cycleCount++;
        observeOutputs();
    endtask

    task automatic readCases();
        int              fd;
        int              n;
        string           line;
        string           name;
        int              opVal;
        int              rdVal;
        int              rs1Val;
        int              rs2Val;
        int              immSel;
        int              zeroVal;
        int              bubbleVal;
        logic [31:0]     immVal;
        logic [31:0]     resVal;
        logic [6:0]      flagVal;
        execPkg::instrT  ins;
        execPkg::resultT expRes;
        fd = $fopen("verif/executeCases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the cases file verif/executeCases.txt");
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%s %d %d %d %d %d %h %h %d %b %d", name, opVal, rdVal,
                            rs1Val, rs2Val, immSel, immVal, resVal, zeroVal, flagVal,
                            bubbleVal);
                if (n != 11) begin
                    $display("Malformed line in cases file: %s", line);
                    errorCount++;
                    continue;
                end
                ins.op        = execPkg::aluOp'(opVal);
                ins.rd        = rdVal[3:0];
                ins.rs1       = rs1Val[3:0];
                ins.rs2       = rs2Val[3:0];
                ins.useImm    = immSel[0];
                ins.imm       = immVal;
                expRes.result = resVal;
                expRes.zero   = zeroVal[0];
                expRes.flags  = flagVal;
                expRes.rd     = rdVal[3:0]; // Result carries its destination
                caseName.push_back(name);
                caseInstr.push_back(ins);
                caseExp.push_back(expRes);
                caseBubble.push_back(bubbleVal[0]);
            end
            $fclose(fd);
        end
    endtask

    initial begin
        wait (cycleLimit > 0);
        repeat (cycleLimit) @(posedge clk);
        $display("Timeout: run went past %0d cycles", cycleLimit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        inValid = 1'b0;
        instr   = '0;
        readCases();
        cycleLimit = caseName.size() * 3 + 50;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (caseName[i]) begin
            stepCycle();
            inValid = 1'b1;
            instr   = caseInstr[i];
            pendName.push_back(caseName[i]);
            pendExp.push_back(caseExp[i]);
            pendCycle.push_back(cycleCount);
            if (caseBubble[i]) begin
                stepCycle();
                inValid = 1'b0;
            end
        end
        stepCycle();
        inValid = 1'b0;
        while (pendName.size() != 0)
            stepCycle(); // Drain the results still in flight

        $display("Tests run %0d, wrong %0d, other errors %0d", doneCount, failCount, errorCount);
        if (errorCount == 0 && failCount == 0 && doneCount == caseName.size() && doneCount > 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/executeCases.txt */
# name op rd rs1 rs2 useImm imm(hex) result(hex) zero flags(bin) bubble
# flags bit 6 overflow, 5 above, 4 equal, 3 below, 0 error; bubble 1 idles a cycle after
ldA        6  1  0  0 1 00000064 00000064 0 0000000 1
ldB        6  2  0  0 1 00000007 00000007 0 0000000 1
add        1  3  1  2 0 00000000 0000006b 0 0000000 1
sub        2  4  2  1 0 00000000 ffffffa3 0 0000000 1
mul        3  5  1  2 0 00000000 000002bc 0 0000000 1
div        4  6  1  2 0 00000000 0000000e 0 0000000 1
ldMax      6  7  0  0 1 7fffffff 7fffffff 0 0000000 1
addOvf     1  8  7  0 1 00000001 80000000 0 1000000 1
mulRange   3  9  7  0 1 00000002 fffffffe 0 1000001 1
divZero    4 10  1  0 0 00000000 00000000 0 0000001 1
and        7 11  1  0 1 0000003c 00000024 0 0000000 1
or         8 12  2  0 1 00000f00 00000f07 0 0000000 1
not       12 13  0  0 1 0000ffff ffff0000 0 0000000 1
shl        9 14  2  0 1 00000003 00000180 0 0000000 1
shrSign   10 15  2  8 0 00000000 ff000000 0 0000000 1
cmpAbove  11  0  1  2 0 00000000 00000000 0 0100000 0
bfjHit    14  0  0  0 1 00001020 00000000 1 0000000 1
bfjMiss   14  0  0  0 1 00000408 00000000 0 0000000 1
cmpEqual  11  0  3  0 1 0000006b 00000000 0 0010000 1
andKeep    7 11  1  0 1 ffffffff 00000064 0 0000000 1
bfjKept   14  0  0  0 1 00000810 00000000 1 0000000 1
cmpBelow  11  0  4  2 0 00000000 00000000 0 0001000 1
jmp       13  0  0  0 0 00000000 00000000 1 0000000 1
nop       15  0  0  0 0 00000000 00000000 1 0000000 1
fwdLd      6  1  0  0 1 00000005 00000005 0 0000000 0
fwdAdd     1  2  1  1 0 00000000 0000000a 0 0000000 0
fwdSub     2  3  2  1 0 00000000 00000005 0 0000000 0
fwdMul     3  4  3  2 0 00000000 00000032 0 0000000 0
fwdShl     9  5  1  4 0 00000000 00000640 0 0000000 0
invalid    0  6  1  2 0 00000000 00000000 1 0000001 0
movOld     5  7  6  0 0 00000000 0000000e 0 0000000 1
bfjError  14  0  0  0 1 00000081 00000000 1 0000000 1

/* sim.f */
hdl/execPkg.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/flagRegister.sv
hdl/executeControl.sv
hdl/executeUnit.sv
verif/executeUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module executeUnitTb -f sim.f -o executeUnitSim

simOutput="$(./obj_dir/executeUnitSim)"
echo "$simOutput"

if grep -qx "TESTS PASSED" <<< "$simOutput"; then
    exit 0
fi
exit 1
